//--- fft_buf_pkg.sv
package fft_buf_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 12;
  localparam int BUF_DW = 64;
  localparam int U_W    = 16;

  localparam logic [1:0]        OPC_START  = 2'b01;   // Command bits 3:2
  localparam logic [ADDR_W-1:0] STATUS_OFS = 12'h000;

  // Float view, x in the low half
  typedef struct packed {
    logic [DATA_W-1:0] y;
    logic [DATA_W-1:0] x;
  } f_word_t;

  // Integer view, only the low 16 bits carry data
  typedef struct packed {
    logic [BUF_DW-U_W-1:0] pad;
    logic [U_W-1:0]        val;
  } u_word_t;

  typedef union packed {
    f_word_t f;
    u_word_t u;
  } buf_word_u;

endpackage

//--- cmd_ctrl.sv
module cmd_ctrl (
  input  logic                           axi_clk,
  input  logic                           axi_reset_n,
  input  logic                           ss_tvalid_i,
  input  logic [fft_buf_pkg::DATA_W-1:0] ss_tdata_i,
  input  logic                           copy_ready_i,
  input  logic                           in_done_i,
  input  logic                           out_done_i,
  input  logic                           clear_i,
  output logic                           ss_tready_o,
  output logic                           copy_en_o,
  output logic                           copy_valid_o,
  output logic                           out_en_o,
  output logic                           uint_mode_o,
  output logic                           done_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COPY,
    ST_OUT,
    ST_DONE
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   start_cmd;

  // Every beat is taken in idle, only opcode 01 starts a frame
  assign start_cmd = (state_q == ST_IDLE) && ss_tvalid_i &&
                     (ss_tdata_i[3:2] == fft_buf_pkg::OPC_START);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_cmd)
          state_d = ST_COPY;
      end
      ST_COPY: begin
        if (in_done_i)
          state_d = ST_OUT;
      end
      ST_OUT: begin
        if (out_done_i)
          state_d = ST_DONE;
      end
      default: begin
        if (clear_i)
          state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      state_q     <= ST_IDLE;
      uint_mode_o <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start_cmd)
        uint_mode_o <= ss_tdata_i[1];   // Modes 2 and 3
    end
  end

  always_comb begin
    case (state_q)
      ST_IDLE: ss_tready_o = 1'b1;
      ST_COPY: ss_tready_o = copy_ready_i;
      default: ss_tready_o = 1'b0;
    endcase
  end

  assign copy_en_o    = (state_q == ST_COPY);
  assign copy_valid_o = copy_en_o && ss_tvalid_i;
  assign out_en_o     = (state_q == ST_OUT);
  assign done_o       = (state_q == ST_DONE);

endmodule

//--- in_copy.sv
module in_copy #(
  parameter int BUF_AW = 10
) (
  input  logic                           axi_clk,
  input  logic                           axi_reset_n,
  input  logic                           copy_en_i,
  input  logic                           uint_mode_i,
  input  logic                           copy_valid_i,
  input  logic [fft_buf_pkg::DATA_W-1:0] ss_tdata_i,
  output logic                           copy_ready_o,
  output logic                           wr_en_o,
  output logic [BUF_AW-1:0]              wr_addr_o,
  output fft_buf_pkg::buf_word_u         wr_word_o,
  output logic                           in_done_o
);

  logic [BUF_AW:0]                cnt_q;    // Words written, MSB set when full
  logic                           half_q;   // x beat held
  logic [fft_buf_pkg::DATA_W-1:0] x_q;
  logic                           beat;

  assign copy_ready_o = copy_en_i && !cnt_q[BUF_AW];
  assign beat         = copy_valid_i && copy_ready_o;
  assign wr_en_o      = beat && (uint_mode_i || half_q);
  assign wr_addr_o    = cnt_q[BUF_AW-1:0];

  always_comb begin
    wr_word_o = '0;
    if (uint_mode_i) begin
      wr_word_o.u.pad = '0;
      wr_word_o.u.val = ss_tdata_i[fft_buf_pkg::U_W-1:0];
    end else begin
      wr_word_o.f.x = x_q;
      wr_word_o.f.y = ss_tdata_i;
    end
  end

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      cnt_q     <= '0;
      half_q    <= 1'b0;
      in_done_o <= 1'b0;
    end else begin
      in_done_o <= wr_en_o && (&cnt_q[BUF_AW-1:0]);   // Last word written
      if (!copy_en_i) begin
        cnt_q  <= '0;
        half_q <= 1'b0;
      end else if (beat) begin
        if (wr_en_o) begin
          cnt_q  <= cnt_q + 1'b1;
          half_q <= 1'b0;
        end else begin
          half_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (beat && !uint_mode_i && !half_q)
      x_q <= ss_tdata_i;
  end

endmodule

//--- frame_buffer.sv
module frame_buffer #(
  parameter int BUF_AW = 10
) (
  input  logic                   axi_clk,
  input  logic                   wr_en_i,
  input  logic [BUF_AW-1:0]      wr_addr_i,
  input  fft_buf_pkg::buf_word_u wr_word_i,
  input  logic                   rd_en_i,
  input  logic [BUF_AW-1:0]      rd_addr_i,
  output fft_buf_pkg::buf_word_u rd_word_o
);

  fft_buf_pkg::buf_word_u mem [2**BUF_AW];

  always_ff @(posedge axi_clk) begin
    if (wr_en_i)
      mem[wr_addr_i] <= wr_word_i;
  end

  // Registered read, data valid the cycle after rd_en
  always_ff @(posedge axi_clk) begin
    if (rd_en_i)
      rd_word_o <= mem[rd_addr_i];
  end

endmodule

//--- out_stream.sv
module out_stream #(
  parameter int BUF_AW = 10
) (
  input  logic                           axi_clk,
  input  logic                           axi_reset_n,
  input  logic                           out_en_i,
  input  logic                           uint_mode_i,
  input  fft_buf_pkg::buf_word_u         rd_word_i,
  input  logic                           sm_tready_i,
  output logic                           rd_en_o,
  output logic [BUF_AW-1:0]              rd_addr_o,
  output logic                           sm_tvalid_o,
  output logic [fft_buf_pkg::DATA_W-1:0] sm_tdata_o,
  output logic                           sm_tlast_o,
  output logic                           out_done_o
);

  localparam int U_W = fft_buf_pkg::U_W;

  logic [BUF_AW:0]        rd_cnt_q;     // Words requested
  logic [BUF_AW:0]        beat_cnt_q;   // Beats accepted
  logic                   rd_pend_q;    // Read data lands this cycle
  logic                   ovalid_q;
  logic                   pvalid_q;
  logic                   ohalf_q;      // x already sent
  fft_buf_pkg::buf_word_u oword_q;
  fft_buf_pkg::buf_word_u pword_q;

  logic       fire;
  logic       word_done;
  logic       out_free;
  logic       load_out;
  logic       load_pref;
  logic [1:0] occ;

  assign fire      = sm_tvalid_o && sm_tready_i;
  assign word_done = fire && (uint_mode_i || ohalf_q);
  assign out_free  = !ovalid_q || word_done;
  assign load_out  = out_free && (pvalid_q || rd_pend_q);
  assign load_pref = rd_pend_q && (!out_free || pvalid_q);

  // Words held or arriving after this cycle, at most two
  assign occ = {1'b0, ovalid_q} + {1'b0, pvalid_q} + {1'b0, rd_pend_q} - {1'b0, word_done};

  assign rd_en_o   = out_en_i && !rd_cnt_q[BUF_AW] && (occ < 2'd2);
  assign rd_addr_o = rd_cnt_q[BUF_AW-1:0];

  assign sm_tvalid_o = ovalid_q;
  assign sm_tlast_o  = uint_mode_i ? (beat_cnt_q == {1'b0, {BUF_AW{1'b1}}}) : (&beat_cnt_q);
  assign out_done_o  = fire && sm_tlast_o;

  always_comb begin
    if (uint_mode_i)
      sm_tdata_o = {{(fft_buf_pkg::DATA_W-U_W){1'b0}}, oword_q.u.val};
    else if (ohalf_q)
      sm_tdata_o = oword_q.f.y;
    else
      sm_tdata_o = oword_q.f.x;
  end

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      rd_cnt_q   <= '0;
      beat_cnt_q <= '0;
      rd_pend_q  <= 1'b0;
      ovalid_q   <= 1'b0;
      pvalid_q   <= 1'b0;
      ohalf_q    <= 1'b0;
    end else if (!out_en_i) begin
      rd_cnt_q   <= '0;
      beat_cnt_q <= '0;
      rd_pend_q  <= 1'b0;
      ovalid_q   <= 1'b0;
      pvalid_q   <= 1'b0;
      ohalf_q    <= 1'b0;
    end else begin
      rd_pend_q <= rd_en_o;
      if (rd_en_o)
        rd_cnt_q <= rd_cnt_q + 1'b1;
      if (fire)
        beat_cnt_q <= beat_cnt_q + 1'b1;
      if (word_done)
        ohalf_q <= 1'b0;
      else if (fire)
        ohalf_q <= 1'b1;
      if (load_out)
        ovalid_q <= 1'b1;
      else if (word_done)
        ovalid_q <= 1'b0;
      if (load_pref)
        pvalid_q <= 1'b1;
      else if (out_free)
        pvalid_q <= 1'b0;   // Moved to the output register
    end
  end

  always_ff @(posedge axi_clk) begin
    if (load_out)
      oword_q <= pvalid_q ? pword_q : rd_word_i;
    if (load_pref)
      pword_q <= rd_word_i;
  end

endmodule

//--- axil_status.sv
module axil_status (
  input  logic                           axi_clk,
  input  logic                           axi_reset_n,
  input  logic                           awvalid_i,
  input  logic [fft_buf_pkg::ADDR_W-1:0] awaddr_i,
  input  logic                           wvalid_i,
  input  logic [fft_buf_pkg::DATA_W-1:0] wdata_i,
  input  logic                           arvalid_i,
  input  logic [fft_buf_pkg::ADDR_W-1:0] araddr_i,
  input  logic                           rready_i,
  input  logic                           done_i,
  output logic                           awready_o,
  output logic                           wready_o,
  output logic                           arready_o,
  output logic                           rvalid_o,
  output logic [fft_buf_pkg::DATA_W-1:0] rdata_o,
  output logic                           clear_o
);

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_t;

  rd_state_t                      rd_state_q;
  logic [fft_buf_pkg::ADDR_W-1:0] rd_addr_q;

  assign awready_o = awvalid_i;
  assign wready_o  = wvalid_i;
  assign arready_o = 1'b1;   // Extra requests while busy are dropped

  assign clear_o = awvalid_i && wvalid_i && (awaddr_i == fft_buf_pkg::STATUS_OFS) && wdata_i[0];

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      rd_state_q <= RD_IDLE;
      rd_addr_q  <= '0;
    end else begin
      case (rd_state_q)
        RD_IDLE: begin
          if (arvalid_i) begin
            rd_addr_q  <= araddr_i;
            rd_state_q <= RD_DATA;
          end
        end
        default: begin
          if (rready_i)
            rd_state_q <= RD_IDLE;
        end
      endcase
    end
  end

  assign rvalid_o = (rd_state_q == RD_DATA);
  assign rdata_o  = (rd_addr_q == fft_buf_pkg::STATUS_OFS) ?
                    {{(fft_buf_pkg::DATA_W-1){1'b0}}, done_i} : '0;

endmodule

//--- user_prj_top.sv
module user_prj_top #(
  parameter int BUF_AW = 10
) (
  input  logic                           axi_clk,
  input  logic                           axi_reset_n,
  input  logic                           awvalid_i,
  input  logic [fft_buf_pkg::ADDR_W-1:0] awaddr_i,
  input  logic                           wvalid_i,
  input  logic [fft_buf_pkg::DATA_W-1:0] wdata_i,
  input  logic                           arvalid_i,
  input  logic [fft_buf_pkg::ADDR_W-1:0] araddr_i,
  input  logic                           rready_i,
  output logic                           awready_o,
  output logic                           wready_o,
  output logic                           arready_o,
  output logic                           rvalid_o,
  output logic [fft_buf_pkg::DATA_W-1:0] rdata_o,
  input  logic                           ss_tvalid_i,
  input  logic [fft_buf_pkg::DATA_W-1:0] ss_tdata_i,
  output logic                           ss_tready_o,
  input  logic                           sm_tready_i,
  output logic                           sm_tvalid_o,
  output logic [fft_buf_pkg::DATA_W-1:0] sm_tdata_o,
  output logic                           sm_tlast_o
);

  logic                   copy_en;
  logic                   copy_valid;
  logic                   copy_ready;
  logic                   in_done;
  logic                   out_en;
  logic                   out_done;
  logic                   uint_mode;
  logic                   done;
  logic                   clear;
  logic                   wr_en;
  logic [BUF_AW-1:0]      wr_addr;
  fft_buf_pkg::buf_word_u wr_word;
  logic                   rd_en;
  logic [BUF_AW-1:0]      rd_addr;
  fft_buf_pkg::buf_word_u rd_word;

  cmd_ctrl u_cmd_ctrl (
    .axi_clk      (axi_clk),
    .axi_reset_n  (axi_reset_n),
    .ss_tvalid_i  (ss_tvalid_i),
    .ss_tdata_i   (ss_tdata_i),
    .copy_ready_i (copy_ready),
    .in_done_i    (in_done),
    .out_done_i   (out_done),
    .clear_i      (clear),
    .ss_tready_o  (ss_tready_o),
    .copy_en_o    (copy_en),
    .copy_valid_o (copy_valid),
    .out_en_o     (out_en),
    .uint_mode_o  (uint_mode),
    .done_o       (done)
  );

  in_copy #(.BUF_AW(BUF_AW)) u_in_copy (
    .axi_clk      (axi_clk),
    .axi_reset_n  (axi_reset_n),
    .copy_en_i    (copy_en),
    .uint_mode_i  (uint_mode),
    .copy_valid_i (copy_valid),
    .ss_tdata_i   (ss_tdata_i),
    .copy_ready_o (copy_ready),
    .wr_en_o      (wr_en),
    .wr_addr_o    (wr_addr),
    .wr_word_o    (wr_word),
    .in_done_o    (in_done)
  );

  frame_buffer #(.BUF_AW(BUF_AW)) u_frame_buffer (
    .axi_clk   (axi_clk),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_word_i (wr_word),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_word_o (rd_word)
  );

  out_stream #(.BUF_AW(BUF_AW)) u_out_stream (
    .axi_clk     (axi_clk),
    .axi_reset_n (axi_reset_n),
    .out_en_i    (out_en),
    .uint_mode_i (uint_mode),
    .rd_word_i   (rd_word),
    .sm_tready_i (sm_tready_i),
    .rd_en_o     (rd_en),
    .rd_addr_o   (rd_addr),
    .sm_tvalid_o (sm_tvalid_o),
    .sm_tdata_o  (sm_tdata_o),
    .sm_tlast_o  (sm_tlast_o),
    .out_done_o  (out_done)
  );

  axil_status u_axil_status (
    .axi_clk     (axi_clk),
    .axi_reset_n (axi_reset_n),
    .awvalid_i   (awvalid_i),
    .awaddr_i    (awaddr_i),
    .wvalid_i    (wvalid_i),
    .wdata_i     (wdata_i),
    .arvalid_i   (arvalid_i),
    .araddr_i    (araddr_i),
    .rready_i    (rready_i),
    .done_i      (done),
    .awready_o   (awready_o),
    .wready_o    (wready_o),
    .arready_o   (arready_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .clear_o     (clear)
  );

endmodule

//--- tb_top.sv
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          DW          = fft_buf_pkg::DATA_W;
  localparam int          AW          = fft_buf_pkg::ADDR_W;
  localparam int          BUF_AW      = 10;
  localparam int          WORDS       = 2 ** BUF_AW;
  localparam int          TIMEOUT_CYC = 4 * 8 * 2 * WORDS + 2000;   // Four frames, 8 cycles a beat
  localparam logic [31:0] SEED        = 32'habe3_b72b;

  logic          axi_clk;
  logic          axi_reset_n;
  logic          awvalid_i;
  logic [AW-1:0] awaddr_i;
  logic          wvalid_i;
  logic [DW-1:0] wdata_i;
  logic          arvalid_i;
  logic [AW-1:0] araddr_i;
  logic          rready_i;
  logic          awready_o;
  logic          wready_o;
  logic          arready_o;
  logic          rvalid_o;
  logic [DW-1:0] rdata_o;
  logic          ss_tvalid_i;
  logic [DW-1:0] ss_tdata_i;
  logic          ss_tready_o;
  logic          sm_tready_i;
  logic          sm_tvalid_o;
  logic [DW-1:0] sm_tdata_o;
  logic          sm_tlast_o;

  logic [DW:0] exp_q[$];   // {tlast, tdata}
  logic        in_gaps;
  logic        out_stalls;
  int          cycles;

  user_prj_top #(.BUF_AW(BUF_AW)) uut (
    .axi_clk     (axi_clk),
    .axi_reset_n (axi_reset_n),
    .awvalid_i   (awvalid_i),
    .awaddr_i    (awaddr_i),
    .wvalid_i    (wvalid_i),
    .wdata_i     (wdata_i),
    .arvalid_i   (arvalid_i),
    .araddr_i    (araddr_i),
    .rready_i    (rready_i),
    .awready_o   (awready_o),
    .wready_o    (wready_o),
    .arready_o   (arready_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .ss_tvalid_i (ss_tvalid_i),
    .ss_tdata_i  (ss_tdata_i),
    .ss_tready_o (ss_tready_o),
    .sm_tready_i (sm_tready_i),
    .sm_tvalid_o (sm_tvalid_o),
    .sm_tdata_o  (sm_tdata_o),
    .sm_tlast_o  (sm_tlast_o)
  );

  initial begin
    axi_clk = 1'b0;
    forever #10 axi_clk = ~axi_clk;
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at %0t", $time);
  endtask

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYC) begin
      @(posedge axi_clk);
      cycles++;
    end
    report_error($sformatf("timeout: run did not finish within %0d cycles", cycles));
  end

  task automatic check_beat(input logic [DW-1:0] got_data, input logic [DW-1:0] exp_data,
                            input logic got_last, input logic exp_last, input string ctx);
    if (got_data !== exp_data)
      report_error($sformatf("mismatch sm_tdata_o (%s): got %h expected %h",
                             ctx, got_data, exp_data));
    if (got_last !== exp_last)
      report_error($sformatf("mismatch sm_tlast_o (%s): got %h expected %h",
                             ctx, got_last, exp_last));
  endtask

  task automatic check_status(input logic [DW-1:0] got, input logic [DW-1:0] exp_data);
    if (got !== exp_data)
      report_error($sformatf("mismatch rdata_o: got %h expected %h", got, exp_data));
  endtask

  task automatic check_ready(input logic got, input logic exp_val);
    if (got !== exp_val)
      report_error($sformatf("mismatch ss_tready_o: got %h expected %h", got, exp_val));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp_val);
    if (got !== exp_val)
      report_error($sformatf("mismatch %s: got %h expected %h", name, got, exp_val));
  endtask

  // Beat moves on the posedge after a negedge that sees ready
  task automatic send_beat(input logic [DW-1:0] data);
    @(posedge axi_clk);
    while (in_gaps && ($urandom_range(3) == 0)) begin
      ss_tvalid_i <= 1'b0;
      @(posedge axi_clk);
    end
    ss_tvalid_i <= 1'b1;
    ss_tdata_i  <= data;
    @(negedge axi_clk);
    while (!ss_tready_o)
      @(negedge axi_clk);
  endtask

  task automatic stop_stream();
    @(posedge axi_clk);
    ss_tvalid_i <= 1'b0;
  endtask

  task automatic drive_out_ready();
    forever begin
      @(posedge axi_clk);
      sm_tready_i <= out_stalls ? ($urandom_range(3) != 0) : 1'b1;
    end
  endtask

  task automatic watch_output();
    logic          held;
    logic [DW-1:0] held_data;
    logic          held_last;
    logic [DW:0]   exp_beat;
    held = 1'b0;
    forever begin
      @(negedge axi_clk);
      if (held) begin
        check_flag("sm_tvalid_o", sm_tvalid_o, 1'b1);
        check_beat(sm_tdata_o, held_data, sm_tlast_o, held_last, "stalled beat");
      end
      if (sm_tvalid_o && sm_tready_i) begin
        held = 1'b0;
        if (exp_q.size() == 0) begin
          report_error("output beat appeared with no frame pending");
        end else begin
          exp_beat = exp_q.pop_front();
          check_beat(sm_tdata_o, exp_beat[DW-1:0], sm_tlast_o, exp_beat[DW], "frame beat");
        end
      end else begin
        held      = sm_tvalid_o;
        held_data = sm_tdata_o;
        held_last = sm_tlast_o;
      end
    end
  endtask

  // rvalid must be low until the edge that takes the address
  task automatic read_status(input logic [AW-1:0] addr, input logic [DW-1:0] exp_data);
    int hold;
    int i;
    hold = $urandom_range(2);
    @(posedge axi_clk);
    arvalid_i <= 1'b1;
    araddr_i  <= addr;
    rready_i  <= 1'b0;
    @(negedge axi_clk);
    check_flag("arready_o", arready_o, 1'b1);
    check_flag("rvalid_o", rvalid_o, 1'b0);
    @(posedge axi_clk);
    arvalid_i <= 1'b0;
    rready_i  <= (hold == 0);
    for (i = 0; i <= hold; i++) begin
      @(negedge axi_clk);
      check_flag("rvalid_o", rvalid_o, 1'b1);
      check_status(rdata_o, exp_data);
      @(posedge axi_clk);
      rready_i <= (i + 1 == hold);
    end
    @(negedge axi_clk);
    check_flag("rvalid_o", rvalid_o, 1'b0);
  endtask

  task automatic clear_done();
    @(posedge axi_clk);
    awvalid_i <= 1'b1;
    awaddr_i  <= fft_buf_pkg::STATUS_OFS;
    wvalid_i  <= 1'b1;
    wdata_i   <= 32'h0000_0001;
    @(negedge axi_clk);
    check_flag("awready_o", awready_o, 1'b1);
    check_flag("wready_o", wready_o, 1'b1);
    @(posedge axi_clk);
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    wdata_i   <= '0;
    @(negedge axi_clk);
    check_flag("awready_o", awready_o, 1'b0);
    check_flag("wready_o", wready_o, 1'b0);
  endtask

  task automatic ignore_command();
    logic [DW-1:0] cmd;
    do
      cmd = $urandom;
    while (cmd[3:2] == fft_buf_pkg::OPC_START);
    send_beat(cmd);
    stop_stream();
    repeat (16) begin
      @(negedge axi_clk);
      check_ready(ss_tready_o, 1'b1);
      check_flag("sm_tvalid_o", sm_tvalid_o, 1'b0);
    end
  endtask

  task automatic run_frame(input logic [1:0] mode, input logic stalls);
    logic [DW-1:0] beats[$];
    logic [DW-1:0] d;
    logic [DW-1:0] cmd;
    logic          last;
    int            n;
    int            i;
    n          = mode[1] ? WORDS : 2 * WORDS;   // Integer frames carry one beat a word
    in_gaps    = stalls;
    out_stalls = stalls;
    for (i = 0; i < n; i++) begin
      d    = $urandom;
      last = (i == n - 1);
      beats.push_back(d);
      if (mode[1])
        exp_q.push_back({last, 16'h0000, d[fft_buf_pkg::U_W-1:0]});
      else
        exp_q.push_back({last, d});
    end
    cmd      = $urandom;
    cmd[3:0] = {fft_buf_pkg::OPC_START, mode};
    @(negedge axi_clk);
    check_ready(ss_tready_o, 1'b1);
    send_beat(cmd);
    foreach (beats[k])
      send_beat(beats[k]);
    stop_stream();
    while (exp_q.size() != 0)
      @(negedge axi_clk);
    @(posedge axi_clk);   // tlast beat taken by now
    @(negedge axi_clk);
    check_ready(ss_tready_o, 1'b0);
    check_flag("sm_tvalid_o", sm_tvalid_o, 1'b0);
    read_status(fft_buf_pkg::STATUS_OFS, 32'h0000_0001);
    read_status(12'h004, 32'h0000_0000);
    read_status(fft_buf_pkg::STATUS_OFS, 32'h0000_0001);
    clear_done();
    @(negedge axi_clk);
    check_ready(ss_tready_o, 1'b1);
    read_status(fft_buf_pkg::STATUS_OFS, 32'h0000_0000);
  endtask

  initial begin
    axi_reset_n = 1'b0;
    awvalid_i   = 1'b0;
    awaddr_i    = '0;
    wvalid_i    = 1'b0;
    wdata_i     = '0;
    arvalid_i   = 1'b0;
    araddr_i    = '0;
    rready_i    = 1'b0;
    ss_tvalid_i = 1'b0;
    ss_tdata_i  = '0;
    sm_tready_i = 1'b0;
    in_gaps     = 1'b0;
    out_stalls  = 1'b0;
    void'($urandom(SEED));
    repeat (10) @(posedge axi_clk);
    axi_reset_n <= 1'b1;
    fork
      drive_out_ready();
      watch_output();
    join_none
    @(negedge axi_clk);
    check_flag("sm_tvalid_o", sm_tvalid_o, 1'b0);
    check_flag("rvalid_o", rvalid_o, 1'b0);
    check_ready(ss_tready_o, 1'b1);
    read_status(fft_buf_pkg::STATUS_OFS, 32'h0000_0000);
    read_status(12'h004, 32'h0000_0000);
    run_frame(2'($urandom_range(1)), 1'b0);
    ignore_command();
    run_frame(2'($urandom_range(3, 2)), 1'b0);
    run_frame(2'($urandom_range(1)), 1'b1);
    run_frame(2'($urandom_range(3, 2)), 1'b1);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- sim.f
fft_buf_pkg.sv
cmd_ctrl.sv
in_copy.sv
frame_buffer.sv
out_stream.sv
axil_status.sv
user_prj_top.sv
tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_top -f sim.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
